/* Makefile */
# Verilator simulation of the pair BTB testbench
# pass is decided by searching the log for the pass message

VERILATOR ?= verilator
TOP       ?= pairBtbTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/brTypePkg.sv */
// Branch type encoding and the stored target word of the pair BTB.
// Only conditional branches and jumps get an entry.
package brTypePkg;

    typedef enum logic [1:0] {
        brNone  = 2'b00,                            // not a branch
        brCond  = 2'b01,                            // conditional branch
        brJump  = 2'b10,                            // unconditional jump
        brOther = 2'b11                             // indirect or return
    } brTypeT;

    // stored word is {target[31:2], type}
    typedef logic [31:0] targetWordT;

    // kept only when the two type bits differ
    function automatic logic isUseful(brTypeT brType);
        return ^brType;
    endfunction

endpackage

/* hdl/btbGeomPkg.sv */
// Geometry of the pair BTB: address width, default set and tag sizes, way count.
// Set index and tag vectors are sized per module from SetBits and TagWidth.
package btbGeomPkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    localparam int AddrWidth   = 32;                // processor address width
    localparam int DefSetBits  = 5;                 // default set index bits
    localparam int DefTagWidth = 24;                // default tag bits
    localparam int NumWays     = 4;                 // fixed way count

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////
    // PC layout: [1:0] ignored, [2] slot, [SetBits+2:3] set, tag above the set
    typedef logic [AddrWidth-1:0] addrT;            // PCs and targets
    typedef logic [NumWays-1:0] wayMaskT;           // one bit per way
    typedef logic [$clog2(NumWays)-1:0] wayIdxT;    // way number

endpackage

/* hdl/btbWay.sv */
// One way of the pair BTB: tag, valid and target arrays for both slots.
// Written by decode builds, read combinationally by decode, execute and fetch.
module btbWay #(
    parameter int SetBits  = btbGeomPkg::DefSetBits,
    parameter int TagWidth = btbGeomPkg::DefTagWidth
) (
    input  logic                  clk,
    input  logic                  rstn,

    // decode build
    input  logic                  wrEn,             // this way is written
    input  btbGeomPkg::addrT      idPc,
    input  brTypePkg::brTypeT     idTypeLower,
    input  brTypePkg::brTypeT     idTypeUpper,
    input  btbGeomPkg::addrT      idTarLower,
    input  btbGeomPkg::addrT      idTarUpper,
    output logic                  idExist,          // a useful slot already here
    output logic                  idInsert,         // no useful slot occupied
    output logic                  idIsPair,         // set holds a full pair

    // execute check
    input  btbGeomPkg::addrT      exPc,
    output logic                  exHit,            // slot picked by exPc[2]

    // fetch lookup
    input  btbGeomPkg::addrT      ifPc,
    output logic                  ifHitLower,
    output logic                  ifHitUpper,
    output brTypePkg::targetWordT ifDataLower,
    output brTypePkg::targetWordT ifDataUpper
);
    import btbGeomPkg::*;
    import brTypePkg::*;

    localparam int NumSets = 1 << SetBits;
    localparam int TagLsb  = SetBits + 3;

    typedef logic [SetBits-1:0] setIdxT;
    typedef logic [TagWidth-1:0] tagT;

    function automatic setIdxT setOf(addrT pc);
        return pc[TagLsb-1:3];
    endfunction

    function automatic tagT tagOf(addrT pc);
        return pc[TagLsb+TagWidth-1:TagLsb];
    endfunction

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    tagT                tagLower [NumSets];
    tagT                tagUpper [NumSets];
    targetWordT         tarLower [NumSets];
    targetWordT         tarUpper [NumSets];
    logic [NumSets-1:0] vldLower;
    logic [NumSets-1:0] vldUpper;

    setIdxT idSet, exSet, ifSet;
    tagT    idTag, exTag, ifTag;
    logic   usefulLower, usefulUpper;
    logic   idVldUsefulLower, idVldUsefulUpper;
    logic   exHitLower, exHitUpper;

    assign idSet = setOf(idPc);
    assign exSet = setOf(exPc);
    assign ifSet = setOf(ifPc);
    assign idTag = tagOf(idPc);
    assign exTag = tagOf(exPc);
    assign ifTag = tagOf(ifPc);

    assign usefulLower = isUseful(idTypeLower);
    assign usefulUpper = isUseful(idTypeUpper);

    //////////////////////////////////////////////////
    // decode side
    //////////////////////////////////////////////////
    assign idVldUsefulLower = vldLower[idSet] & usefulLower;
    assign idVldUsefulUpper = vldUpper[idSet] & usefulUpper;

    assign idIsPair = vldLower[idSet] & vldUpper[idSet]
                    & (tagLower[idSet] == tagUpper[idSet]);
    assign idExist  = (idVldUsefulLower & (tagLower[idSet] == idTag))
                    | (idVldUsefulUpper & (tagUpper[idSet] == idTag));
    assign idInsert = ~(idVldUsefulLower | idVldUsefulUpper);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vldLower <= '0;
            vldUpper <= '0;
        end else if (wrEn) begin
            if (idIsPair) begin
                // a pair is replaced as a whole
                vldLower[idSet] <= usefulLower;
                vldUpper[idSet] <= usefulUpper;
            end else begin
                vldLower[idSet] <= vldLower[idSet] | usefulLower;
                vldUpper[idSet] <= vldUpper[idSet] | usefulUpper;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn && usefulLower) begin
            tagLower[idSet] <= idTag;
            tarLower[idSet] <= {idTarLower[AddrWidth-1:2], idTypeLower};
        end
        if (wrEn && usefulUpper) begin
            tagUpper[idSet] <= idTag;
            tarUpper[idSet] <= {idTarUpper[AddrWidth-1:2], idTypeUpper};
        end
    end

    //////////////////////////////////////////////////
    // execute and fetch reads
    //////////////////////////////////////////////////
    assign exHitLower = vldLower[exSet] & (tagLower[exSet] == exTag);
    assign exHitUpper = vldUpper[exSet] & (tagUpper[exSet] == exTag);
    assign exHit      = exPc[2] ? exHitUpper : exHitLower;

    assign ifHitLower  = vldLower[ifSet] & (tagLower[ifSet] == ifTag);
    assign ifHitUpper  = vldUpper[ifSet] & (tagUpper[ifSet] == ifTag);
    assign ifDataLower = tarLower[ifSet];
    assign ifDataUpper = tarUpper[ifSet];

endmodule

/* hdl/fillSelect.sv */
// Picks the way a decode build writes, as a one-hot write enable.
// Existing entry: no write. Else first free way, else the victim.
module fillSelect (
    input  logic                idEn,
    input  btbGeomPkg::wayMaskT idExist,        // per-way block already present
    input  btbGeomPkg::wayMaskT idInsert,       // per-way free slot space
    input  btbGeomPkg::wayIdxT  victim,
    output btbGeomPkg::wayMaskT wrWay
);
    import btbGeomPkg::*;

    wayMaskT firstFree;
    wayMaskT victimMask;

    assign victimMask = wayMaskT'(1) << victim;

    // lowest free way wins
    always_comb begin
        firstFree = '0;
        for (int w = NumWays - 1; w >= 0; w--) begin
            if (idInsert[w]) begin
                firstFree    = '0;
                firstFree[w] = 1'b1;
            end
        end
    end

    always_comb begin
        if (!idEn || (|idExist)) begin
            wrWay = '0;                         // nothing to build
        end else if (|idInsert) begin
            wrWay = firstFree;
        end else begin
            wrWay = victimMask;                 // all ways taken
        end
    end

endmodule

/* hdl/hitMerge.sv */
// Merges the per-way hit flags of the execute check and the fetch lookup.
// Fetch data comes from the lowest way with either slot hitting.
module hitMerge (
    input  logic                  exVld,
    input  btbGeomPkg::wayMaskT   exHit,
    input  btbGeomPkg::wayMaskT   ifHitLower,
    input  btbGeomPkg::wayMaskT   ifHitUpper,
    input  brTypePkg::targetWordT ifDataLowerWay [btbGeomPkg::NumWays],
    input  brTypePkg::targetWordT ifDataUpperWay [btbGeomPkg::NumWays],

    output logic                  exExist,
    output logic                  confirm,          // feeds victim tracking
    output btbGeomPkg::wayIdxT    confirmWay,

    output logic                  ifExistLower,
    output logic                  ifExistUpper,
    output btbGeomPkg::wayIdxT    ifWay,
    output brTypePkg::targetWordT ifDataLower,
    output brTypePkg::targetWordT ifDataUpper
);
    import btbGeomPkg::*;

    wayMaskT ifHitAny;

    assign ifHitAny = ifHitLower | ifHitUpper;

    //////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////
    assign exExist = |exHit;
    assign confirm = exVld & exExist;

    always_comb begin
        confirmWay = wayIdxT'(NumWays - 1);
        for (int w = NumWays - 1; w >= 0; w--) begin
            if (exHit[w]) begin
                confirmWay = wayIdxT'(w);
            end
        end
    end

    //////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////
    assign ifExistLower = |ifHitLower;
    assign ifExistUpper = |ifHitUpper;

    // top way is the fallback on a total miss
    always_comb begin
        ifWay       = wayIdxT'(NumWays - 1);
        ifDataLower = ifDataLowerWay[NumWays-1];
        ifDataUpper = ifDataUpperWay[NumWays-1];
        for (int w = NumWays - 1; w >= 0; w--) begin
            if (ifHitAny[w]) begin
                ifWay       = wayIdxT'(w);
                ifDataLower = ifDataLowerWay[w];
                ifDataUpper = ifDataUpperWay[w];
            end
        end
    end

endmodule

/* hdl/pairBtb.sv */
// Top level of the 4-way pair BTB: decode build, execute check, fetch lookup.
// Instantiates the ways, fill selection, hit merging and victim tracking.
module pairBtb #(
    parameter int SetBits  = btbGeomPkg::DefSetBits,
    parameter int TagWidth = btbGeomPkg::DefTagWidth
) (
    input  logic                  clk,
    input  logic                  rstn,

    // decode build
    input  logic                  idEn,             // single-cycle strobe
    input  btbGeomPkg::addrT      idPc,
    input  brTypePkg::brTypeT     idTypeLower,
    input  brTypePkg::brTypeT     idTypeUpper,
    input  btbGeomPkg::addrT      idTarLower,
    input  btbGeomPkg::addrT      idTarUpper,

    // execute check
    input  logic                  exVld,            // single-cycle strobe
    input  btbGeomPkg::addrT      exPc,
    output logic                  exExist,

    // fetch lookup
    input  btbGeomPkg::addrT      ifPc,
    output logic                  ifExistLower,
    output logic                  ifExistUpper,
    output btbGeomPkg::wayIdxT    ifWay,
    output brTypePkg::targetWordT ifDataLower,
    output brTypePkg::targetWordT ifDataUpper
);
    import btbGeomPkg::*;
    import brTypePkg::*;

    wayMaskT    wrWay;
    wayMaskT    idExist, idInsert;
    wayMaskT    exHit;
    wayMaskT    ifHitLower, ifHitUpper;
    targetWordT ifDataLowerWay [NumWays];
    targetWordT ifDataUpperWay [NumWays];
    wayIdxT     victim;
    wayIdxT     confirmWay;
    logic       confirm;

    //////////////////////////////////////////////////
    // ways
    //////////////////////////////////////////////////
    for (genvar w = 0; w < NumWays; w++) begin : gWay
        btbWay #(
            .SetBits     (SetBits),
            .TagWidth    (TagWidth)
        ) btbWay_inst (
            .clk         (clk),
            .rstn        (rstn),
            .wrEn        (wrWay[w]),
            .idPc        (idPc),
            .idTypeLower (idTypeLower),
            .idTypeUpper (idTypeUpper),
            .idTarLower  (idTarLower),
            .idTarUpper  (idTarUpper),
            .idExist     (idExist[w]),
            .idInsert    (idInsert[w]),
            .idIsPair    (),                        // only used by the way's write rule
            .exPc        (exPc),
            .exHit       (exHit[w]),
            .ifPc        (ifPc),
            .ifHitLower  (ifHitLower[w]),
            .ifHitUpper  (ifHitUpper[w]),
            .ifDataLower (ifDataLowerWay[w]),
            .ifDataUpper (ifDataUpperWay[w])
        );
    end

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    fillSelect fillSelect_inst (
        .idEn     (idEn),
        .idExist  (idExist),
        .idInsert (idInsert),
        .victim   (victim),
        .wrWay    (wrWay)
    );

    victimTracker #(
        .SetBits    (SetBits)
    ) victimTracker_inst (
        .clk        (clk),
        .rstn       (rstn),
        .confirm    (confirm),
        .confirmPc  (exPc),
        .confirmWay (confirmWay),
        .buildPc    (idPc),
        .victim     (victim)
    );

    hitMerge hitMerge_inst (
        .exVld          (exVld),
        .exHit          (exHit),
        .ifHitLower     (ifHitLower),
        .ifHitUpper     (ifHitUpper),
        .ifDataLowerWay (ifDataLowerWay),
        .ifDataUpperWay (ifDataUpperWay),
        .exExist        (exExist),
        .confirm        (confirm),
        .confirmWay     (confirmWay),
        .ifExistLower   (ifExistLower),
        .ifExistUpper   (ifExistUpper),
        .ifWay          (ifWay),
        .ifDataLower    (ifDataLower),
        .ifDataUpper    (ifDataUpper)
    );

endmodule

/* hdl/victimTracker.sv */
// Per-set replacement state: remembers the last way confirmed by execute.
// The victim for a build is the way after the last confirmed one.
module victimTracker #(
    parameter int SetBits = btbGeomPkg::DefSetBits
) (
    input  logic               clk,
    input  logic               rstn,

    input  logic               confirm,         // execute hit accepted
    input  btbGeomPkg::addrT   confirmPc,
    input  btbGeomPkg::wayIdxT confirmWay,

    input  btbGeomPkg::addrT   buildPc,
    output btbGeomPkg::wayIdxT victim
);
    import btbGeomPkg::*;

    localparam int NumSets = 1 << SetBits;

    typedef logic [SetBits-1:0] setIdxT;

    wayIdxT lastWay [NumSets];                  // last confirmed way per set
    setIdxT confirmSet;
    setIdxT buildSet;

    assign confirmSet = confirmPc[SetBits+2:3];
    assign buildSet   = buildPc[SetBits+2:3];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // start at the top way so the first victim is way 0
            for (int s = 0; s < NumSets; s++) begin
                lastWay[s] <= wayIdxT'(NumWays - 1);
            end
        end else if (confirm) begin
            lastWay[confirmSet] <= confirmWay;
        end
    end

    assign victim = lastWay[buildSet] + wayIdxT'(1);  // wraps mod 4

endmodule

/* sources.f */
hdl/btbGeomPkg.sv
hdl/brTypePkg.sv
hdl/btbWay.sv
hdl/victimTracker.sv
hdl/fillSelect.sv
hdl/hitMerge.sv
hdl/pairBtb.sv
tb/pairBtbTb.sv

/* tb/pairBtbTb.sv */
// Testbench for the pair BTB with a reference model of the build, fill, victim and fetch rules.
// Drives random and directed blocks, checks with assertions, prints one line per test.
module pairBtbTb;
    import btbGeomPkg::*;
    import brTypePkg::*;

    localparam int SetBits     = DefSetBits;
    localparam int TagWidth    = DefTagWidth;
    localparam int NumSets     = 1 << SetBits;
    localparam int ResetCycles = 16;
    // one cycle per build, lookup or confirm
    localparam int TestCycles    = ResetCycles + 20 + 6 + 5 + 4 + 11 + 13;
    localparam int TimeoutCycles = 2 * TestCycles;

    logic       clk = 1'b0;
    logic       rstn;
    logic       idEn;
    addrT       idPc, idTarLower, idTarUpper;
    brTypeT     idTypeLower, idTypeUpper;
    logic       exVld;
    addrT       exPc, ifPc;
    logic       exExist, ifExistLower, ifExistUpper;
    wayIdxT     ifWay;
    targetWordT ifDataLower, ifDataUpper;

    int seed = 32'ha8d1_4737;
    int errCount = 0;
    int testErrStart;
    int testCount = 0;
    int failedTests = 0;
    int cycleCount = 0;

    // reference model with one entry per way and set
    logic [TagWidth-1:0] mTagLo [NumWays][NumSets];
    logic [TagWidth-1:0] mTagHi [NumWays][NumSets];
    logic [31:0]         mTarLo [NumWays][NumSets];
    logic [31:0]         mTarHi [NumWays][NumSets];
    logic                mVldLo [NumWays][NumSets];
    logic                mVldHi [NumWays][NumSets];
    int                  mLast  [NumSets];             // last confirmed way

    // outputs seen by the last lookup
    logic       gotEx, gotLo, gotHi;
    int         gotWay;
    targetWordT gotDataLo, gotDataHi;

    pairBtb #(
        .SetBits      (SetBits),
        .TagWidth     (TagWidth)
    ) pairBtb_inst (
        .clk          (clk),
        .rstn         (rstn),
        .idEn         (idEn),
        .idPc         (idPc),
        .idTypeLower  (idTypeLower),
        .idTypeUpper  (idTypeUpper),
        .idTarLower   (idTarLower),
        .idTarUpper   (idTarUpper),
        .exVld        (exVld),
        .exPc         (exPc),
        .exExist      (exExist),
        .ifPc         (ifPc),
        .ifExistLower (ifExistLower),
        .ifExistUpper (ifExistUpper),
        .ifWay        (ifWay),
        .ifDataLower  (ifDataLower),
        .ifDataUpper  (ifDataUpper)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Test failures found");
            $finish;
        end
    end

    // a reset cycle leaves every way empty
    quietOutOfReset: assert property (@(posedge clk)
        !rstn |=> !(exExist || ifExistLower || ifExistUpper) && (ifWay == wayIdxT'(3)))
    else begin
        errCount++;
        $display("a hit or a wrong ifWay was seen right after a reset cycle");
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic usefulType(input logic [1:0] t);
        return t[1] != t[0];                           // cond or jump only
    endfunction

    function automatic int setOf(input addrT pc);
        return int'(pc[3 +: SetBits]);
    endfunction

    function automatic logic [TagWidth-1:0] tagOf(input addrT pc);
        return pc[SetBits+3 +: TagWidth];
    endfunction

    function automatic addrT makePc(input logic [TagWidth-1:0] tag, input int setIdx,
                                    input logic slot);
        return AddrWidth'({tag, SetBits'(setIdx), slot, 2'b00});
    endfunction

    function automatic logic [TagWidth-1:0] randomTag();
        return TagWidth'($random(seed));
    endfunction

    function automatic logic slotHit(input int w, input addrT pc, input logic upper);
        if (upper) begin
            return mVldHi[w][setOf(pc)] && (mTagHi[w][setOf(pc)] == tagOf(pc));
        end
        return mVldLo[w][setOf(pc)] && (mTagLo[w][setOf(pc)] == tagOf(pc));
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expV,
                              input logic [31:0] gotV);
        assert (gotV === expV) else begin
            errCount++;
            $display("ERR %s expected %h got %h", name, expV, gotV);
        end
    endtask

    //////////////////////////////////////////////////
    // bus operations taking one cycle each from edge+1
    //////////////////////////////////////////////////
    task automatic buildBlock(input addrT pc, input brTypeT typeLo, input brTypeT typeHi,
                              input addrT tarLo, input addrT tarHi);
        int   s;
        int   fillWay;
        logic useLo, useHi, exists, pairNow;
        s       = setOf(pc);
        useLo   = usefulType(typeLo);
        useHi   = usefulType(typeHi);
        exists  = 1'b0;
        fillWay = -1;
        for (int w = NumWays - 1; w >= 0; w--) begin
            if ((mVldLo[w][s] && useLo && mTagLo[w][s] == tagOf(pc))
                || (mVldHi[w][s] && useHi && mTagHi[w][s] == tagOf(pc))) begin
                exists = 1'b1;
            end
            if (!((mVldLo[w][s] && useLo) || (mVldHi[w][s] && useHi))) begin
                fillWay = w;                           // lowest free way
            end
        end
        if (exists) begin
            fillWay = -1;
        end else if (fillWay < 0) begin
            fillWay = (mLast[s] + 1) % NumWays;        // victim
        end
        idEn        = 1'b1;
        idPc        = pc;
        idTypeLower = typeLo;
        idTypeUpper = typeHi;
        idTarLower  = tarLo;
        idTarUpper  = tarHi;
        @(posedge clk);
        #1;
        idEn = 1'b0;
        if (fillWay >= 0) begin
            pairNow = mVldLo[fillWay][s] && mVldHi[fillWay][s]
                      && (mTagLo[fillWay][s] == mTagHi[fillWay][s]);
            if (useLo) begin
                mTagLo[fillWay][s] = tagOf(pc);
                mTarLo[fillWay][s] = {tarLo[31:2], typeLo};
            end
            if (useHi) begin
                mTagHi[fillWay][s] = tagOf(pc);
                mTarHi[fillWay][s] = {tarHi[31:2], typeHi};
            end
            mVldLo[fillWay][s] = pairNow ? useLo : (mVldLo[fillWay][s] | useLo);
            mVldHi[fillWay][s] = pairNow ? useHi : (mVldHi[fillWay][s] | useHi);
        end
    endtask

    task automatic lookup(input addrT fetchPc, input addrT checkPc);
        logic expEx, expLo, expHi;
        int   expWay;
        int   fs;
        expEx  = 1'b0;
        expLo  = 1'b0;
        expHi  = 1'b0;
        expWay = NumWays - 1;                          // total miss
        fs     = setOf(fetchPc);
        for (int w = NumWays - 1; w >= 0; w--) begin
            expEx = expEx | slotHit(w, checkPc, checkPc[2]);
            expLo = expLo | slotHit(w, fetchPc, 1'b0);
            expHi = expHi | slotHit(w, fetchPc, 1'b1);
            if (slotHit(w, fetchPc, 1'b0) || slotHit(w, fetchPc, 1'b1)) begin
                expWay = w;
            end
        end
        ifPc = fetchPc;
        exPc = checkPc;
        @(negedge clk);
        gotEx     = exExist;
        gotLo     = ifExistLower;
        gotHi     = ifExistUpper;
        gotWay    = int'(ifWay);
        gotDataLo = ifDataLower;
        gotDataHi = ifDataUpper;
        checkValue("exExist", 32'(expEx), 32'(exExist));
        checkValue("ifExistLower", 32'(expLo), 32'(ifExistLower));
        checkValue("ifExistUpper", 32'(expHi), 32'(ifExistUpper));
        checkValue("ifWay", expWay, 32'(ifWay));
        if (slotHit(expWay, fetchPc, 1'b0)) begin
            checkValue("ifDataLower", mTarLo[expWay][fs], ifDataLower);
        end
        if (slotHit(expWay, fetchPc, 1'b1)) begin
            checkValue("ifDataUpper", mTarHi[expWay][fs], ifDataUpper);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic confirmHit(input addrT pc);
        int hitWay;
        hitWay = -1;
        for (int w = NumWays - 1; w >= 0; w--) begin
            if (slotHit(w, pc, pc[2])) begin
                hitWay = w;
            end
        end
        exVld = 1'b1;
        exPc  = pc;
        @(negedge clk);
        checkValue("exExist", 32'(hitWay >= 0), 32'(exExist));
        @(posedge clk);
        #1;
        exVld = 1'b0;
        if (hitWay >= 0) begin
            mLast[setOf(pc)] = hitWay;
        end
    endtask

    task automatic startTest();
        testErrStart = errCount;
        testCount++;
    endtask

    task automatic endTest(input string name);
        if (errCount == testErrStart) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, errCount - testErrStart);
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic quietAfterReset();
        startTest();
        repeat (20) begin
            lookup(addrT'($random(seed)), addrT'($random(seed)));
        end
        endTest("empty after reset");
    endtask

    task automatic buildAndFetch();
        addrT pcA, pcB, pcC;
        addrT tar [6];
        for (int i = 0; i < 6; i++) begin
            tar[i] = addrT'($random(seed));
        end
        startTest();
        pcA = makePc(randomTag(), 1, 1'b0);
        pcB = makePc(randomTag(), 2, 1'b1);
        pcC = makePc(randomTag(), 3, 1'b0);
        buildBlock(pcA, brCond, brNone, tar[0], tar[1]);
        buildBlock(pcB, brOther, brJump, tar[2], tar[3]);
        buildBlock(pcC, brJump, brCond, tar[4], tar[5]);
        lookup(pcA, pcA);
        checkValue("ifExistUpper", 32'h0, 32'(gotHi));
        checkValue("ifDataLower", {tar[0][31:2], 2'b01}, gotDataLo);
        lookup(pcB, pcB);
        checkValue("ifExistLower", 32'h0, 32'(gotLo));
        checkValue("ifDataUpper", {tar[3][31:2], 2'b10}, gotDataHi);
        lookup(pcC, pcC);
        checkValue("ifDataLower", {tar[4][31:2], 2'b10}, gotDataLo);
        checkValue("ifDataUpper", {tar[5][31:2], 2'b01}, gotDataHi);
        endTest("build then fetch");
    endtask

    task automatic slotSelect();
        logic [TagWidth-1:0] tag;
        tag = randomTag();
        startTest();
        buildBlock(makePc(tag, 5, 1'b0), brCond, brNone, addrT'($random(seed)), 32'h0);
        lookup(makePc(tag, 5, 1'b0), makePc(tag, 5, 1'b0));
        checkValue("exExist", 32'h1, 32'(gotEx));
        lookup(makePc(tag, 5, 1'b0), makePc(tag, 5, 1'b1));
        checkValue("exExist", 32'h0, 32'(gotEx));
        lookup(makePc(tag, 5, 1'b0), makePc(tag + 1'b1, 5, 1'b0));
        checkValue("exExist", 32'h0, 32'(gotEx));
        lookup(makePc(tag, 5, 1'b0), makePc(tag, 6, 1'b0));
        checkValue("exExist", 32'h0, 32'(gotEx));
        endTest("execute slot select");
    endtask

    task automatic rebuildKeepsOld();
        addrT pc, tarOld;
        pc     = makePc(randomTag(), 7, 1'b0);
        tarOld = addrT'($random(seed));
        startTest();
        buildBlock(pc, brCond, brNone, tarOld, tarOld);
        lookup(pc, pc);
        // a stray write would show up as an upper hit
        buildBlock(pc, brCond, brJump, ~tarOld, ~tarOld);
        lookup(pc, pc);
        checkValue("ifDataLower", {tarOld[31:2], 2'b01}, gotDataLo);
        checkValue("ifExistUpper", 32'h0, 32'(gotHi));
        endTest("rebuild writes nothing");
    endtask

    task automatic fillOrder();
        logic [TagWidth-1:0] base;
        base = randomTag();
        startTest();
        for (int i = 0; i < NumWays; i++) begin
            buildBlock(makePc(base + TagWidth'(i), 10, 1'b0), brCond, brJump,
                       addrT'($random(seed)), addrT'($random(seed)));
        end
        for (int i = 0; i < NumWays; i++) begin
            lookup(makePc(base + TagWidth'(i), 10, 1'b0), exPc);
            checkValue("ifWay", i, gotWay);
        end
        // lower only, so the old upper of the pair must drop out
        buildBlock(makePc(base + TagWidth'(4), 10, 1'b0), brJump, brNone,
                   addrT'($random(seed)), addrT'($random(seed)));
        lookup(makePc(base + TagWidth'(4), 10, 1'b0), exPc);
        checkValue("ifWay", 0, gotWay);
        lookup(makePc(base, 10, 1'b0), exPc);          // evicted tag
        checkValue("ifExistLower", 32'h0, 32'(gotLo));
        checkValue("ifExistUpper", 32'h0, 32'(gotHi));
        endTest("fill order and first victim");
    endtask

    task automatic victimAfterConfirm();
        logic [TagWidth-1:0] base;
        int                  k;
        base = randomTag();
        k    = $unsigned($random(seed)) % 3;           // way 3 gives the reset victim
        startTest();
        for (int s = 20; s <= 21; s++) begin
            for (int i = 0; i < NumWays; i++) begin
                buildBlock(makePc(base + TagWidth'(i), s, 1'b0), brCond, brJump,
                           addrT'($random(seed)), addrT'($random(seed)));
            end
        end
        confirmHit(makePc(base + TagWidth'(k), 20, 1'($random(seed))));
        for (int s = 20; s <= 21; s++) begin
            buildBlock(makePc(base + TagWidth'(8), s, 1'b0), brJump, brJump,
                       addrT'($random(seed)), addrT'($random(seed)));
            lookup(makePc(base + TagWidth'(8), s, 1'b0), exPc);
            checkValue("ifWay", (s == 20) ? (k + 1) % NumWays : 0, gotWay);
        end
        endTest("victim after confirm");
    endtask

    //////////////////////////////////////////////////
    // main flow
    //////////////////////////////////////////////////
    initial begin
        rstn        = 1'b0;
        idEn        = 1'b0;
        idPc        = '0;
        idTypeLower = brNone;
        idTypeUpper = brNone;
        idTarLower  = '0;
        idTarUpper  = '0;
        exVld       = 1'b0;
        exPc        = '0;
        ifPc        = '0;
        for (int s = 0; s < NumSets; s++) begin
            mLast[s] = NumWays - 1;                    // first victim is way 0
            for (int w = 0; w < NumWays; w++) begin
                mVldLo[w][s] = 1'b0;
                mVldHi[w][s] = 1'b0;
            end
        end
        repeat (ResetCycles) begin
            @(posedge clk);
            #1;
            ifPc = addrT'($random(seed));
            exPc = addrT'($random(seed));
        end
        rstn = 1'b1;

        quietAfterReset();
        buildAndFetch();
        slotSelect();
        rebuildKeepsOld();
        fillOrder();
        victimAfterConfirm();

        $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
